// ==== store_settings.svh ====
`ifndef STORE_SETTINGS_SVH
`define STORE_SETTINGS_SVH

`define XLEN 32

// ------------------------------------------------------------------------
// core memory map, inclusive bounds.
// ------------------------------------------------------------------------

`define BOOT_REGION_START      32'h0000_0000 // not writable.
`define BOOT_REGION_END        32'h0000_0FFF

`define INT_TABLE_REGION_START 32'h0000_1000 // cachable only.
`define INT_TABLE_REGION_END   32'h0000_10FF

`define EXT_NVM_REGION_START   32'h0000_2000
`define EXT_NVM_REGION_END     32'h0000_2FFF

`define INT_NVM_REGION_START   32'h0000_3000
`define INT_NVM_REGION_END     32'h0000_3FFF

`define CODE_REGION_START      32'h0000_4000
`define CODE_REGION_END        32'h0000_7FFF

// peripheral space, neither cachable nor bufferable.
`define TIMERS_REGION_START    32'h0000_8000
`define TIMERS_REGION_END      32'h0000_80FF

`define IO_REGION_START        32'h0000_9000
`define IO_REGION_END          32'h0000_9FFF

`define SYSTEM_REGION_START    32'h0000_A000
`define SYSTEM_REGION_END      32'h0000_AFFF

// ------------------------------------------------------------------------
// cache model and exceptions.
// ------------------------------------------------------------------------

`define CACHE_WRITE_LATENCY    3     // capture to done, in cycles.
`define DATA_WORDS             64    // data array depth.

`define ILLEGAL_MEMORY_ACCESS  5'd5

`endif

// ==== store_pkg.sv ====
`include "store_settings.svh"

package store_pkg;

    // ------------------------------------------------------------------------
    // widths with a meaning.
    // ------------------------------------------------------------------------

    typedef logic [`XLEN - 1:0] data_word_t;  // one data word.
    typedef logic [`XLEN - 1:0] address_t;    // byte address.

    typedef logic [3:0] instr_tag_t;          // reorder buffer tag.
    typedef logic [4:0] exc_vector_t;

    // ------------------------------------------------------------------------
    // store encodings.
    // ------------------------------------------------------------------------

    // store opcode as seen from issue.
    typedef enum logic [1:0] {
        SB,
        SH,
        SW
    } stu_operation_t;

    // access width towards the cache and commit.
    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } mem_op_width_t;

endpackage : store_pkg

// ==== store_agu.sv ====
`timescale 1ns/1ps

module store_agu (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // issue side.
    input  logic                      issue_i,
    input  store_pkg::address_t       base_i,
    input  store_pkg::address_t       offset_i,
    input  store_pkg::data_word_t     store_data_i,
    input  store_pkg::stu_operation_t operation_i,
    input  store_pkg::instr_tag_t     tag_i,
    output logic                      issue_busy_o,

    // towards the store unit.
    input  logic                      accept_i,
    output logic                      valid_operation_o,
    output store_pkg::address_t       store_address_o,
    output store_pkg::data_word_t     store_data_o,
    output store_pkg::stu_operation_t operation_o,
    output store_pkg::instr_tag_t     tag_o
);

    import store_pkg::*;

    logic           full_q;
    logic           load;

    address_t       address_q;
    data_word_t     data_q;
    stu_operation_t operation_q;
    instr_tag_t     tag_q;

    assign load = issue_i & ~full_q; // only an empty slot takes a store.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (accept_i) begin
            full_q <= 1'b0;
        end
    end

    // effective address is formed at issue and held until accepted.
    always_ff @(posedge clk_i) begin
        if (load) begin
            address_q   <= base_i + offset_i;
            data_q      <= store_data_i;
            operation_q <= operation_i;
            tag_q       <= tag_i;
        end
    end

    assign valid_operation_o = full_q;
    assign issue_busy_o      = full_q;

    assign store_address_o   = address_q;
    assign store_data_o      = data_q;
    assign operation_o       = operation_q;
    assign tag_o             = tag_q;

endmodule : store_agu

// ==== store_unit.sv ====
`timescale 1ns/1ps

`include "store_settings.svh"

module store_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // from the address generation stage.
    input  logic                      valid_operation_i,
    input  store_pkg::data_word_t     store_data_i,
    input  store_pkg::address_t       store_address_i,
    input  store_pkg::stu_operation_t operation_i,
    input  store_pkg::instr_tag_t     tag_i,
    output logic                      accept_o,

    // commit side.
    input  logic                      data_accepted_i,
    output store_pkg::instr_tag_t     tag_o,
    output logic                      exception_o,
    output store_pkg::exc_vector_t    exc_vector_o,
    output store_pkg::mem_op_width_t  store_width_o,
    output store_pkg::data_word_t     store_data_o,
    output store_pkg::address_t       store_address_o,
    output logic                      idle_o,
    output logic                      data_valid_o,

    // cache controller.
    input  logic                      cache_ctrl_store_done_i,
    input  logic                      cache_ctrl_store_idle_i,
    output logic                      data_bufferable_o,
    output logic                      data_cachable_o,
    output logic                      cache_ctrl_write_o
);

    import store_pkg::*;

    function automatic logic inside_range(address_t lo, address_t hi, address_t addr);
        return (addr >= lo) && (addr <= hi);
    endfunction

    // ------------------------------------------------------------------------
    // address attributes.
    // ------------------------------------------------------------------------

    logic cachable;
    logic bufferable;
    logic writable;
    logic nvm_or_code;

    assign nvm_or_code = inside_range(`EXT_NVM_REGION_START, `EXT_NVM_REGION_END, store_address_i)
                       | inside_range(`INT_NVM_REGION_START, `INT_NVM_REGION_END, store_address_i)
                       | inside_range(`CODE_REGION_START, `CODE_REGION_END, store_address_i);

    assign cachable   = nvm_or_code
                      | inside_range(`INT_TABLE_REGION_START, `INT_TABLE_REGION_END,
                                     store_address_i);
    assign bufferable = nvm_or_code;
    assign writable   = !inside_range(`BOOT_REGION_START, `BOOT_REGION_END, store_address_i);

    // ------------------------------------------------------------------------
    // state and held store.
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {IDLE, WAIT_CACHE, WAIT_COMMIT} stu_state_t;

    stu_state_t    state_q,       state_d;
    logic          cache_write_q, cache_write_d;
    logic          cachable_q,    cachable_d;
    logic          bufferable_q,  bufferable_d;

    address_t      address_q,     address_d;
    data_word_t    data_q,        data_d;
    mem_op_width_t width_q,       width_d;
    instr_tag_t    tag_q,         tag_d;
    logic          exception_q,   exception_d;
    exc_vector_t   exc_vector_q,  exc_vector_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= IDLE;
            cache_write_q <= 1'b0;
            cachable_q    <= 1'b1;
            bufferable_q  <= 1'b1;
        end else begin
            state_q       <= state_d;
            cache_write_q <= cache_write_d;
            cachable_q    <= cachable_d;
            bufferable_q  <= bufferable_d;
        end
    end

    always_ff @(posedge clk_i) begin
        address_q    <= address_d;
        data_q       <= data_d;
        width_q      <= width_d;
        tag_q        <= tag_d;
        exception_q  <= exception_d;
        exc_vector_q <= exc_vector_d;
    end

    always_comb begin
        state_d       = state_q;
        cache_write_d = cache_write_q;
        cachable_d    = cachable_q;
        bufferable_d  = bufferable_q;
        address_d     = address_q;
        data_d        = data_q;
        width_d       = width_q;
        tag_d         = tag_q;
        exception_d   = exception_q;
        exc_vector_d  = exc_vector_q;
        accept_o      = 1'b0;

        case (state_q)
            IDLE: begin
                if (valid_operation_i && cache_ctrl_store_idle_i) begin
                    accept_o     = 1'b1;
                    address_d    = store_address_i;
                    data_d       = store_data_i;
                    tag_d        = tag_i;
                    cachable_d   = cachable;
                    bufferable_d = bufferable;

                    if (writable) begin
                        exception_d   = 1'b0;
                        exc_vector_d  = '0;
                        cache_write_d = 1'b1;
                        state_d       = WAIT_CACHE;
                    end else begin
                        // boot region, straight to commit with the fault.
                        exception_d   = 1'b1;
                        exc_vector_d  = `ILLEGAL_MEMORY_ACCESS;
                        state_d       = WAIT_COMMIT;
                    end

                    case (operation_i)
                        SB:      width_d = BYTE;
                        SH:      width_d = HALF_WORD;
                        default: width_d = WORD;
                    endcase
                end
            end

            WAIT_CACHE: begin
                if (cache_ctrl_store_done_i) begin
                    cache_write_d = 1'b0;
                    state_d       = WAIT_COMMIT;
                end
            end

            WAIT_COMMIT: begin
                if (data_accepted_i) state_d = IDLE;
            end

            default: state_d = IDLE;
        endcase
    end

    assign idle_o             = (state_d == IDLE);
    assign data_valid_o       = (state_q == WAIT_COMMIT);
    assign cache_ctrl_write_o = cache_write_q;

    assign data_cachable_o    = cachable_q;
    assign data_bufferable_o  = bufferable_q;
    assign store_address_o    = address_q;
    assign store_data_o       = data_q;
    assign store_width_o      = width_q;
    assign tag_o              = tag_q;
    assign exception_o        = exception_q;
    assign exc_vector_o       = exc_vector_q;

endmodule : store_unit

// ==== store_cache_ctrl.sv ====
`timescale 1ns/1ps

`include "store_settings.svh"

module store_cache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // write port from the store unit.
    input  logic                     write_i,
    input  store_pkg::address_t      address_i,
    input  store_pkg::data_word_t    data_i,
    input  store_pkg::mem_op_width_t width_i,
    output logic                     store_done_o,
    output logic                     store_idle_o,

    // debug read port.
    input  store_pkg::address_t      rd_addr_i,
    output store_pkg::data_word_t    rd_data_o
);

    import store_pkg::*;

    localparam int LATENCY = `CACHE_WRITE_LATENCY;
    localparam int CNT_W   = (LATENCY > 1) ? $clog2(LATENCY) : 1;
    localparam int IDX_W   = $clog2(`DATA_WORDS);

    typedef enum logic {READY, WRITING} cache_state_t;

    cache_state_t  state_q;
    logic [CNT_W - 1:0] cnt_q;

    address_t      address_q;
    data_word_t    data_q;
    mem_op_width_t width_q;

    data_word_t    data_array [`DATA_WORDS];
    data_word_t    merged;
    logic [IDX_W - 1:0] wr_idx;

    // ------------------------------------------------------------------------
    // control.
    // ------------------------------------------------------------------------

    assign store_done_o = (state_q == WRITING) && (cnt_q == CNT_W'(LATENCY - 1));
    assign store_idle_o = (state_q == READY);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= READY;
            cnt_q   <= '0;
        end else if (state_q == READY) begin
            if (write_i) begin
                state_q <= WRITING;
                cnt_q   <= '0;
            end
        end else if (store_done_o) begin
            state_q <= READY;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // inputs sampled straight from the port in the capture cycle.
    always_ff @(posedge clk_i) begin
        if ((state_q == READY) && write_i) begin
            address_q <= address_i;
            data_q    <= data_i;
            width_q   <= width_i;
        end
    end

    // ------------------------------------------------------------------------
    // data array.
    // ------------------------------------------------------------------------

    assign wr_idx = address_q[IDX_W + 1:2];

    always_comb begin
        merged = data_array[wr_idx];
        case (width_q)
            BYTE:      merged[{address_q[1:0], 3'b000} +: 8] = data_q[7:0];
            HALF_WORD: merged[{address_q[1], 4'b0000} +: 16] = data_q[15:0];
            default:   merged = data_q;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (store_done_o) data_array[wr_idx] <= merged; // same edge as the done pulse.
    end

    assign rd_data_o = data_array[rd_addr_i[IDX_W + 1:2]];

endmodule : store_cache_ctrl

// ==== store_subsystem.sv ====
`timescale 1ns/1ps

module store_subsystem (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    // issue.
    input  logic                      issue_i,
    input  store_pkg::address_t       base_i,
    input  store_pkg::address_t       offset_i,
    input  store_pkg::data_word_t     store_data_i,
    input  store_pkg::stu_operation_t operation_i,
    input  store_pkg::instr_tag_t     tag_i,
    output logic                      issue_busy_o,

    // commit.
    input  logic                      data_accepted_i,
    output store_pkg::instr_tag_t     tag_o,
    output logic                      exception_o,
    output store_pkg::exc_vector_t    exc_vector_o,
    output store_pkg::address_t       store_address_o,
    output store_pkg::mem_op_width_t  store_width_o,
    output logic                      data_valid_o,
    output logic                      data_cachable_o,
    output logic                      data_bufferable_o,
    output logic                      idle_o,

    // debug read of the data array.
    input  store_pkg::address_t       rd_addr_i,
    output store_pkg::data_word_t     rd_data_o
);

    import store_pkg::*;

    // agu to store unit.
    logic           agu_valid;
    logic           agu_accept;
    address_t       agu_address;
    data_word_t     agu_data;
    stu_operation_t agu_operation;
    instr_tag_t     agu_tag;

    // store unit to cache controller.
    logic           cache_write;
    logic           cache_done;
    logic           cache_idle;
    data_word_t     cache_data;

    store_agu u_agu (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .issue_i           (issue_i),
        .base_i            (base_i),
        .offset_i          (offset_i),
        .store_data_i      (store_data_i),
        .operation_i       (operation_i),
        .tag_i             (tag_i),
        .issue_busy_o      (issue_busy_o),
        .accept_i          (agu_accept),
        .valid_operation_o (agu_valid),
        .store_address_o   (agu_address),
        .store_data_o      (agu_data),
        .operation_o       (agu_operation),
        .tag_o             (agu_tag)
    );

    store_unit u_store_unit (
        .clk_i                   (clk_i),
        .rst_n_i                 (rst_n_i),
        .valid_operation_i       (agu_valid),
        .store_data_i            (agu_data),
        .store_address_i         (agu_address),
        .operation_i             (agu_operation),
        .tag_i                   (agu_tag),
        .accept_o                (agu_accept),
        .data_accepted_i         (data_accepted_i),
        .tag_o                   (tag_o),
        .exception_o             (exception_o),
        .exc_vector_o            (exc_vector_o),
        .store_width_o           (store_width_o),
        .store_data_o            (cache_data),
        .store_address_o         (store_address_o),
        .idle_o                  (idle_o),
        .data_valid_o            (data_valid_o),
        .cache_ctrl_store_done_i (cache_done),
        .cache_ctrl_store_idle_i (cache_idle),
        .data_bufferable_o       (data_bufferable_o),
        .data_cachable_o         (data_cachable_o),
        .cache_ctrl_write_o      (cache_write)
    );

    // address and width are shared with the commit outputs.
    store_cache_ctrl u_cache_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_i      (cache_write),
        .address_i    (store_address_o),
        .data_i       (cache_data),
        .width_i      (store_width_o),
        .store_done_o (cache_done),
        .store_idle_o (cache_idle),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o)
    );

endmodule : store_subsystem

// ==== store_subsystem_sva.sv ====
`timescale 1ns/1ps

module store_subsystem_sva (
    input logic clk_i,
    input logic rst_n_i,
    input logic cache_write_i,
    input logic data_valid_i,
    input logic data_accepted_i,
    input logic exception_i
);

    // a store is either in the cache or waiting for commit.
    write_vs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(cache_write_i && data_valid_i))
        else $error("cache write and data valid high in the same cycle");

    valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (data_valid_i && !data_accepted_i) |=> data_valid_i)
        else $error("data valid dropped without data accepted");

    // faulting store never reaches the cache.
    fault_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exception_i |-> !cache_write_i)
        else $error("cache write raised for a faulting store");

endmodule : store_subsystem_sva

bind store_unit store_subsystem_sva u_sva (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cache_write_i   (cache_ctrl_write_o),
    .data_valid_i    (data_valid_o),
    .data_accepted_i (data_accepted_i),
    .exception_i     (exception_o)
);

// ==== store_subsystem_tb.sv ====
`timescale 1ns/1ps

`include "store_settings.svh"

module store_subsystem_tb;

    import store_pkg::*;

    localparam int MAX_ENTRIES = 40;
    localparam int IDX_W       = $clog2(`DATA_WORDS);

    logic           clk_i;
    logic           rst_n_i;
    logic           issue_i;
    address_t       base_i;
    address_t       offset_i;
    data_word_t     store_data_i;
    stu_operation_t operation_i;
    instr_tag_t     tag_i;
    logic           issue_busy_o;
    logic           data_accepted_i;
    instr_tag_t     tag_o;
    logic           exception_o;
    exc_vector_t    exc_vector_o;
    address_t       store_address_o;
    mem_op_width_t  store_width_o;
    logic           data_valid_o;
    logic           data_cachable_o;
    logic           data_bufferable_o;
    logic           idle_o;
    address_t       rd_addr_i;
    data_word_t     rd_data_o;

    // stimulus table and expected results.
    stu_operation_t t_op      [MAX_ENTRIES];
    address_t       t_base    [MAX_ENTRIES];
    address_t       t_offset  [MAX_ENTRIES];
    data_word_t     t_data    [MAX_ENTRIES];
    instr_tag_t     t_tag     [MAX_ENTRIES];
    logic           t_timed   [MAX_ENTRIES]; // measured issue to data valid.
    logic           x_exc     [MAX_ENTRIES];
    logic [1:0]     x_attr    [MAX_ENTRIES]; // {cachable, bufferable}.
    data_word_t     x_word    [MAX_ENTRIES];
    data_word_t     shadow    [`DATA_WORDS];
    int             issue_cycle [MAX_ENTRIES];
    int             test_errors [MAX_ENTRIES + 1];

    int             n_entries;
    int             committed;
    int             errors;
    int             cycle = 0;
    logic [15:0]    lfsr_state;

    store_subsystem DUT (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .issue_i           (issue_i),
        .base_i            (base_i),
        .offset_i          (offset_i),
        .store_data_i      (store_data_i),
        .operation_i       (operation_i),
        .tag_i             (tag_i),
        .issue_busy_o      (issue_busy_o),
        .data_accepted_i   (data_accepted_i),
        .tag_o             (tag_o),
        .exception_o       (exception_o),
        .exc_vector_o      (exc_vector_o),
        .store_address_o   (store_address_o),
        .store_width_o     (store_width_o),
        .data_valid_o      (data_valid_o),
        .data_cachable_o   (data_cachable_o),
        .data_bufferable_o (data_bufferable_o),
        .idle_o            (idle_o),
        .rd_addr_i         (rd_addr_i),
        .rd_data_o         (rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    // ------------------------------------------------------------------------
    // reference rules.
    // ------------------------------------------------------------------------

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [1:0] region_attrs(address_t a);
        if (a >= `INT_TABLE_REGION_START && a <= `INT_TABLE_REGION_END) return 2'b10;
        if (a >= `EXT_NVM_REGION_START && a <= `EXT_NVM_REGION_END) return 2'b11;
        if (a >= `INT_NVM_REGION_START && a <= `INT_NVM_REGION_END) return 2'b11;
        if (a >= `CODE_REGION_START && a <= `CODE_REGION_END) return 2'b11;
        return 2'b00; // boot and peripherals.
    endfunction

    function automatic mem_op_width_t expected_width(stu_operation_t op);
        if (op == SB) return BYTE;
        if (op == SH) return HALF_WORD;
        return WORD;
    endfunction

    function automatic data_word_t merge_store(data_word_t old, data_word_t data,
                                               stu_operation_t op, address_t addr);
        logic [3:0] lanes;
        data_word_t placed;
        data_word_t result;
        if (op == SB) begin
            lanes  = 4'b0001 << addr[1:0];
            placed = {4{data[7:0]}};
        end else if (op == SH) begin
            lanes  = addr[1] ? 4'b1100 : 4'b0011;
            placed = {2{data[15:0]}};
        end else begin
            lanes  = 4'b1111;
            placed = data;
        end
        for (int b = 0; b < 4; b++) begin
            result[8 * b +: 8] = lanes[b] ? placed[8 * b +: 8] : old[8 * b +: 8];
        end
        return result;
    endfunction

    task automatic add_entry(input stu_operation_t op, input address_t base,
                             input address_t offset, input data_word_t data,
                             input instr_tag_t tag, input logic timed);
        address_t       addr;
        logic [IDX_W - 1:0] idx;
        addr = base + offset;
        idx  = addr[IDX_W + 1:2];
        t_op[n_entries]     = op;
        t_base[n_entries]   = base;
        t_offset[n_entries] = offset;
        t_data[n_entries]   = data;
        t_tag[n_entries]    = tag;
        t_timed[n_entries]  = timed;
        x_exc[n_entries]    = (addr >= `BOOT_REGION_START) && (addr <= `BOOT_REGION_END);
        x_attr[n_entries]   = region_attrs(addr);
        if (!x_exc[n_entries]) shadow[idx] = merge_store(shadow[idx], data, op, addr);
        x_word[n_entries]   = shadow[idx];
        n_entries++;
    endtask

    task automatic build_table();
        // code region, word then halfword and byte lanes.
        add_entry(SW, 32'h0000_4000, 32'h0000_0040, 32'h1122_3344, 4'd1, 1'b1);
        add_entry(SH, 32'h0000_4000, 32'h0000_0042, 32'hAAAA_BEEF, 4'd2, 1'b0);
        add_entry(SH, 32'h0000_4040, 32'h0000_0000, 32'h5555_CAFE, 4'd3, 1'b0);
        add_entry(SB, 32'h0000_4040, 32'h0000_0001, 32'h0000_00A1, 4'd4, 1'b0);
        add_entry(SB, 32'h0000_4050, 32'hFFFF_FFF2, 32'h0000_00B2, 4'd5, 1'b0);
        add_entry(SB, 32'h0000_4050, 32'hFFFF_FFF3, 32'hFFFF_FFC3, 4'd6, 1'b0);
        add_entry(SB, 32'h0000_4040, 32'h0000_0000, 32'h1234_56D4, 4'd7, 1'b0);
        add_entry(SW, 32'h0000_7000, 32'h0000_0FFC, 32'hDEAD_BEEF, 4'd8, 1'b0);
        // int table, then peripherals.
        add_entry(SW, 32'h0000_1000, 32'h0000_0008, 32'h0BAD_F00D, 4'd9, 1'b0);
        add_entry(SB, 32'h0000_1000, 32'h0000_0009, 32'h0000_0077, 4'd10, 1'b0);
        add_entry(SW, 32'h0000_9000, 32'h0000_0010, 32'h9090_9090, 4'd11, 1'b0);
        add_entry(SH, 32'h0000_9000, 32'h0000_0012, 32'h0000_1234, 4'd12, 1'b0);
        add_entry(SW, 32'h0000_8000, 32'h0000_0014, 32'h8080_0014, 4'd13, 1'b0);
        add_entry(SW, 32'h0000_A000, 32'h0000_0018, 32'hA0A0_A0A0, 4'd14, 1'b0);
        add_entry(SB, 32'h0000_A000, 32'h0000_001B, 32'h0000_005A, 4'd15, 1'b0);
        add_entry(SW, 32'h0000_2000, 32'h0000_0020, 32'h2020_2020, 4'd0, 1'b0);
        add_entry(SW, 32'h0000_3000, 32'h0000_0024, 32'h3030_3030, 4'd1, 1'b0);
        add_entry(SH, 32'h0000_3000, 32'h0000_0026, 32'h0000_3E3E, 4'd2, 1'b0);
        // boot region faults, array words stay.
        add_entry(SW, 32'h0000_4000, 32'h0000_00C0, 32'hC0C0_C0C0, 4'd3, 1'b0);
        add_entry(SW, 32'h0000_0000, 32'h0000_00C0, 32'hFFFF_FFFF, 4'd4, 1'b0);
        add_entry(SB, 32'h0000_0F00, 32'h0000_00FF, 32'h0000_0011, 4'd5, 1'b0);
        add_entry(SW, 32'h0000_5000, 32'h0000_0004, 32'h5A5A_0004, 4'd6, 1'b1);
        // back to back into one word.
        add_entry(SW, 32'h0000_4060, 32'h0000_0000, 32'h0000_0000, 4'd7, 1'b0);
        add_entry(SB, 32'h0000_4060, 32'h0000_0003, 32'h0000_00EE, 4'd8, 1'b0);
        add_entry(SB, 32'h0000_4060, 32'h0000_0002, 32'h0000_00DD, 4'd9, 1'b0);
        add_entry(SH, 32'h0000_4060, 32'h0000_0000, 32'h0000_BBCC, 4'd10, 1'b0);
        add_entry(SB, 32'h0000_4060, 32'h0000_0000, 32'h0000_0099, 4'd11, 1'b0);
        add_entry(SH, 32'h0000_4060, 32'h0000_0002, 32'h0000_7766, 4'd12, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // reporting.
    // ------------------------------------------------------------------------

    task automatic report_mismatch(input int t, input string name,
                                   input data_word_t got, input data_word_t exp);
        $display("Fail %s: got %h, expected %h (test %0d)", name, got, exp, t);
        errors++;
        test_errors[t]++;
    endtask

    task automatic print_result(input int t);
        if (test_errors[t] == 0) begin
            $display("test %0d passed", t);
        end else begin
            $display("test %0d failed with %0d errors", t, test_errors[t]);
        end
    endtask

    task automatic check_reset();
        if (data_valid_o !== 1'b0) report_mismatch(0, "data_valid_o", data_valid_o, 0);
        if (issue_busy_o !== 1'b0) report_mismatch(0, "issue_busy_o", issue_busy_o, 0);
        if (idle_o !== 1'b1) report_mismatch(0, "idle_o", idle_o, 1);
        if (data_cachable_o !== 1'b1) report_mismatch(0, "data_cachable_o", data_cachable_o, 1);
        if (data_bufferable_o !== 1'b1) begin
            report_mismatch(0, "data_bufferable_o", data_bufferable_o, 1);
        end
        print_result(0);
    endtask

    // ------------------------------------------------------------------------
    // issue and commit sides.
    // ------------------------------------------------------------------------

    task automatic issue_stores();
        for (int k = 0; k < n_entries; k++) begin
            do begin
                @(posedge clk_i);
                #1;
            end while (issue_busy_o || (t_timed[k] && committed < k));
            base_i         = t_base[k];
            offset_i       = t_offset[k];
            store_data_i   = t_data[k];
            operation_i    = t_op[k];
            tag_i          = t_tag[k];
            issue_i        = 1'b1;
            issue_cycle[k] = cycle;
            @(posedge clk_i);
            #1;
            issue_i = 1'b0;
            if (issue_busy_o !== 1'b1) report_mismatch(k + 1, "issue_busy_o", issue_busy_o, 1);
            while (issue_busy_o) begin
                @(posedge clk_i);
                #1;
            end
            if (committed < k) begin
                $display("test %0d: issue_busy_o dropped before the previous store committed",
                         k + 1);
                errors++;
                test_errors[k + 1]++;
            end
        end
    endtask

    task automatic commit_stores();
        int delay;
        int seen;
        for (int k = 0; k < n_entries; k++) begin
            do begin
                @(posedge clk_i);
                #1;
            end while (!data_valid_o);
            seen = cycle;
            if (t_timed[k] && (seen - issue_cycle[k]) != 6) begin
                report_mismatch(k + 1, "data_valid_o latency", seen - issue_cycle[k], 6);
            end
            if (tag_o !== t_tag[k]) report_mismatch(k + 1, "tag_o", tag_o, t_tag[k]);
            if (exception_o !== x_exc[k]) begin
                report_mismatch(k + 1, "exception_o", exception_o, x_exc[k]);
            end
            if (exc_vector_o !== (x_exc[k] ? `ILLEGAL_MEMORY_ACCESS : 5'd0)) begin
                report_mismatch(k + 1, "exc_vector_o", exc_vector_o,
                                x_exc[k] ? `ILLEGAL_MEMORY_ACCESS : 5'd0);
            end
            if (store_address_o !== t_base[k] + t_offset[k]) begin
                report_mismatch(k + 1, "store_address_o", store_address_o,
                                t_base[k] + t_offset[k]);
            end
            if (store_width_o !== expected_width(t_op[k])) begin
                report_mismatch(k + 1, "store_width_o", 32'(store_width_o),
                                32'(expected_width(t_op[k])));
            end
            if (data_cachable_o !== x_attr[k][1]) begin
                report_mismatch(k + 1, "data_cachable_o", data_cachable_o, x_attr[k][1]);
            end
            if (data_bufferable_o !== x_attr[k][0]) begin
                report_mismatch(k + 1, "data_bufferable_o", data_bufferable_o, x_attr[k][0]);
            end

            random_bits(2, delay);
            if (t_timed[k]) delay = 0;
            repeat (delay) begin
                @(posedge clk_i);
                #1;
                if (!data_valid_o) begin
                    $display("test %0d: data_valid_o dropped before data_accepted_i", k + 1);
                    errors++;
                    test_errors[k + 1]++;
                end
            end

            data_accepted_i = 1'b1;
            rd_addr_i       = t_base[k] + t_offset[k];
            #1;
            if (idle_o !== 1'b1) report_mismatch(k + 1, "idle_o", idle_o, 1);
            if (rd_data_o !== x_word[k]) report_mismatch(k + 1, "rd_data_o", rd_data_o, x_word[k]);
            committed++;
            @(posedge clk_i);
            #1;
            data_accepted_i = 1'b0;
            print_result(k + 1);
        end
    endtask

    initial begin
        int timeout_cycles;
        lfsr_state      = 16'd49;
        n_entries       = 0;
        committed       = 0;
        errors          = 0;
        rst_n_i         = 1'b0;
        issue_i         = 1'b0;
        base_i          = '0;
        offset_i        = '0;
        store_data_i    = '0;
        operation_i     = SW;
        tag_i           = '0;
        data_accepted_i = 1'b0;
        rd_addr_i       = '0;
        for (int t = 0; t <= MAX_ENTRIES; t++) test_errors[t] = 0;
        build_table();
        timeout_cycles = n_entries * 20 + 100;

        fork
            begin
                repeat (timeout_cycles) @(posedge clk_i);
                $display("watchdog expired after %0d cycles, stores did not complete",
                         timeout_cycles);
                $display("TESTS FAILED");
                $finish;
            end
        join_none

        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        check_reset();

        fork
            issue_stores();
            commit_stores();
        join

        $display("%0d tests run, %0d checks failed", n_entries + 1, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : store_subsystem_tb

// ==== all.f ====
+incdir+.
store_pkg.sv
store_agu.sv
store_unit.sv
store_cache_ctrl.sv
store_subsystem.sv
store_subsystem_sva.sv
store_subsystem_tb.sv

// ==== run.sh ====
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module store_subsystem_tb -o store_sim

./obj_dir/store_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

grep -q "TESTS PASSED" sim.log
echo "simulation passed"
